/* tb/nes_loader_input.txt */
// kind 1 = image: 16 header bytes, invert_mirroring, expected mapper flags, expect error
// kind 2 = joypads: joy_a, joy_b, joy_swap; kind 0 ends the records
// Accepted image, one PRG and one CHR page, vertical mirroring
1
4E 45 53 1A 01 01 01 00 00 00 00 00 00 00 00 00
0 00004000 0
// Bad magic, sizes that saturate the CHR size code
1
4E 45 53 1B 05 FF 00 00 00 00 00 00 00 00 00 00
0 00003B00 1
// Trainer bit set
1
4E 45 53 1A 02 02 04 00 00 00 00 00 00 00 00 00
0 00000900 1
// CHR RAM, four screen, dirty header, mirroring inverted
1
4E 45 53 1A 01 00 F9 A0 00 00 00 00 00 00 00 07
1 0001800F 0
// Joypad reads, with and without swap
2 A5 3C 0
2 A5 3C 1
2 81 7E 0
2 FF 00 1
0

/* nes_loader.f */
src/nes_loader_pkg.sv
src/nes_input_pkg.sv
src/nes_reset_ctrl.sv
src/ines_loader.sv
src/rom_write_stage.sv
src/joypad_serial.sv
src/nes_loader_top.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_nes_loader.sv

/* Bender.yml */
package:
  name: nes_loader

sources:
  - src/nes_loader_pkg.sv
  - src/nes_input_pkg.sv
  - src/nes_reset_ctrl.sv
  - src/ines_loader.sv
  - src/rom_write_stage.sv
  - src/joypad_serial.sv
  - src/nes_loader_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_checker.sv
      - tb/tb_nes_loader.sv

/* tb/tb_nes_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cartridge loader testbench
// Replays the input records into the DUT
// on falling clock edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_nes_loader;

	localparam int vec_words = 256;
	localparam int byte_period = 8;      // Cycles between downloader strobes
	localparam int done_timeout = 64;
	localparam int release_timeout = 400;

	logic                          clk;
	logic                          reset;
	logic                          downloading;
	nes_loader_pkg::load_byte_t    load;
	logic                          invert_mirroring;
	logic                          user_reset;
	nes_input_pkg::pad_state_t     joy_a;
	nes_input_pkg::pad_state_t     joy_b;
	logic                          joy_swap;
	nes_input_pkg::joypad_bus_t    joypad;
	nes_loader_pkg::rom_write_t    mem;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	logic                          load_done;
	logic                          load_error;
	logic                          nes_reset;
	logic                          nes_run;
	logic [1:0]                    joypad_data;

	nes_loader_pkg::mapper_flags_t exp_flags;  // Expectations handed to the checker
	logic                          exp_error;
	int                            check_errors;
	int                            pending_writes;
	int                            tb_errors;
	logic                          abort;      // Set by a timeout, skips the rest
	logic [15:0]                   lfsr_state;
	logic [31:0]                   vec [0:vec_words-1];
	int                            base;
	int                            records;
	int                            cycles;

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	nes_loader_top nes_loader_top_i (
		.clk              (clk),
		.reset            (reset),
		.downloading      (downloading),
		.load             (load),
		.invert_mirroring (invert_mirroring),
		.user_reset       (user_reset),
		.joy_a            (joy_a),
		.joy_b            (joy_b),
		.joy_swap         (joy_swap),
		.joypad           (joypad),
		.mem              (mem),
		.mapper_flags     (mapper_flags),
		.load_done        (load_done),
		.load_error       (load_error),
		.nes_reset        (nes_reset),
		.nes_run          (nes_run),
		.joypad_data      (joypad_data)
	);

	tb_checker checker_i (
		.clk            (clk),
		.reset          (reset),
		.downloading    (downloading),
		.load           (load),
		.user_reset     (user_reset),
		.joy_a          (joy_a),
		.joy_b          (joy_b),
		.joy_swap       (joy_swap),
		.joypad         (joypad),
		.mem            (mem),
		.mapper_flags   (mapper_flags),
		.load_done      (load_done),
		.load_error     (load_error),
		.nes_reset      (nes_reset),
		.nes_run        (nes_run),
		.joypad_data    (joypad_data),
		.exp_flags      (exp_flags),
		.exp_error      (exp_error),
		.errors         (check_errors),
		.pending_writes (pending_writes)
	);

	// Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// One LFSR step per payload bit
	task automatic next_payload_byte(output logic [7:0] b);
		b = 8'd0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		if (!abort) begin
			@(negedge clk);
			load.byte_data = b;
			load.strobe = 1'b1;
			@(negedge clk);
			load.strobe = 1'b0;
			repeat (byte_period - 2) @(negedge clk);
		end
	endtask

	task automatic wait_for_done();
		int n;
		n = 0;
		while (!abort && load_done !== 1'b1 && n < done_timeout) begin
			@(negedge clk);
			n++;
		end
		if (!abort && load_done !== 1'b1) begin
			$display("timed out waiting for load_done at %0t ns", $time);
			tb_errors++;
			abort = 1'b1;
		end
	endtask

	task automatic wait_for_release();
		int n;
		n = 0;
		while (!abort && nes_reset !== 1'b0 && n < release_timeout) begin
			@(negedge clk);
			n++;
		end
		if (!abort && nes_reset !== 1'b0) begin
			$display("timed out waiting for nes_reset to fall at %0t ns", $time);
			tb_errors++;
			abort = 1'b1;
		end
	endtask

	task automatic load_image(input int at);
		int payload;
		logic [7:0] b;
		@(negedge clk);
		invert_mirroring = vec[at+17][0];
		exp_flags = vec[at+18];
		exp_error = vec[at+19][0];
		downloading = 1'b1;
		for (int i = 1; i <= 16; i++)
			send_byte(vec[at+i][7:0]);
		if (exp_error)
			payload = 16;                  // Trailing bytes that must never be written
		else
			payload = vec[at+5] * 16384 + vec[at+6] * 8192;
		for (int k = 0; k < payload && !abort; k++) begin
			next_payload_byte(b);
			send_byte(b);
		end
		wait_for_done();
		@(negedge clk);
		downloading = 1'b0;
		if (exp_error)
			repeat (300) @(negedge clk);
		else
			wait_for_release();
	endtask

	// Strobe, then ten reads per port, two past the last button
	task automatic read_pads(input int at);
		@(negedge clk);
		joy_a = vec[at+1][7:0];
		joy_b = vec[at+2][7:0];
		joy_swap = vec[at+3][0];
		@(negedge clk);
		joypad.strobe = 1'b1;
		@(negedge clk);
		joypad.strobe = 1'b0;
		for (int p = 0; p < 2; p++) begin
			for (int k = 0; k < 10; k++) begin
				@(negedge clk);
				joypad.clocks[p] = 1'b1;
				@(negedge clk);
				joypad.clocks[p] = 1'b0;
				@(negedge clk);
			end
		end
	endtask

	initial begin
		downloading = 1'b0;
		load = '0;
		invert_mirroring = 1'b0;
		user_reset = 1'b0;
		joy_a = '0;
		joy_b = '0;
		joy_swap = 1'b0;
		joypad = '0;
		exp_flags = '0;
		exp_error = 1'b0;
		tb_errors = 0;
		abort = 1'b0;
		lfsr_state = 16'd89;
		records = 0;
		$readmemh("tb/nes_loader_input.txt", vec);

		cycles = 0;
		while (reset !== 1'b0 && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			tb_errors++;
			abort = 1'b1;
		end
		repeat (12) @(negedge clk);  // Idle with the console held before any download

		base = 0;
		while (!abort && base < vec_words - 20 && (vec[base] == 32'd1 || vec[base] == 32'd2)) begin
			if (vec[base] == 32'd1) begin
				load_image(base);
				base = base + 20;
			end else begin
				read_pads(base);
				base = base + 4;
			end
			records++;
		end
		if (!abort && records == 0) begin
			$display("no test records were read from the input file");
			tb_errors++;
		end

		@(negedge clk);
		user_reset = 1'b1;
		repeat (2) @(negedge clk);
		user_reset = 1'b0;
		repeat (8) @(negedge clk);
		if (pending_writes != 0) begin
			$display("%0d expected memory writes never arrived", pending_writes);
			tb_errors++;
		end

		$display("checker errors: %0d, testbench errors: %0d", check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loader checker
// Watches the DUT ports on rising edges and
// compares them with expected behavior
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          downloading,
	input  nes_loader_pkg::load_byte_t    load,
	input  logic                          user_reset,
	input  nes_input_pkg::pad_state_t     joy_a,
	input  nes_input_pkg::pad_state_t     joy_b,
	input  logic                          joy_swap,
	input  nes_input_pkg::joypad_bus_t    joypad,
	input  nes_loader_pkg::rom_write_t    mem,
	input  nes_loader_pkg::mapper_flags_t mapper_flags,
	input  logic                          load_done,
	input  logic                          load_error,
	input  logic                          nes_reset,
	input  logic                          nes_run,
	input  logic [1:0]                    joypad_data,
	input  nes_loader_pkg::mapper_flags_t exp_flags,
	input  logic                          exp_error,
	output int                            errors,
	output int                            pending_writes
);

	logic [7:0]  hdr [16];
	int          hdr_cnt;
	int          payload_cnt;
	int          prg_len;
	int          chr_len;
	logic [29:0] exp_q [$];          // {addr, data} in arrival order
	logic [29:0] exp_w;
	logic        reset_q = 1'b0;
	logic        downloading_q = 1'b0;
	logic        done_q1 = 1'b0;
	logic        done_q2 = 1'b0;
	logic        seen_download = 1'b0;
	logic        run_seen = 1'b0;
	int          run_gap;
	int          done_wait;          // Cycles left until load_done is due
	logic        counting = 1'b0;
	int          high_cycles;
	logic [7:0]  pad_src [2];
	int          pad_idx [2];
	logic        pad_valid = 1'b0;
	logic [1:0]  clocks_q = 2'b00;

	initial begin
		errors = 0;
		pending_writes = 0;
	end

	task automatic report_mismatch(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// The console reads A, B, select, start, then up, down, left, right
	function automatic logic first_out_bit(input logic [7:0] src, input int k);
		case (k)
			0: return src[4];
			1: return src[5];
			2: return src[6];
			3: return src[7];
			4: return src[3];
			5: return src[2];
			6: return src[1];
			7: return src[0];
			default: return 1'b0;
		endcase
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			run_seen = 1'b0;
			run_gap = 0;
			hdr_cnt = 0;
			payload_cnt = 0;
			done_wait = 0;
			counting = 1'b0;
			pad_valid = 1'b0;
			seen_download = 1'b0;
		end else begin
			if (reset_q && (load_done !== 1'b0 || load_error !== 1'b0 ||
					mem.write !== 1'b0 || mapper_flags !== '0))
				report_mismatch("outputs not cleared by reset");
			if (downloading)
				seen_download = 1'b1;
			if (!seen_download && nes_reset !== 1'b1)
				report_mismatch("nes_reset low before the first download");
			if ((user_reset || load_error) && nes_reset !== 1'b1)
				report_mismatch("nes_reset low during user_reset or load_error");

			// nes_run must come exactly every fourth cycle
			if (nes_run) begin
				if (run_seen && run_gap != 3)
					report_mismatch($sformatf("nes_run gap of %0d cycles", run_gap + 1));
				run_seen = 1'b1;
				run_gap = 0;
			end else begin
				run_gap++;
				if (run_gap == 4)
					report_mismatch("nes_run missing in a four cycle window");
			end

			if (done_wait > 0) begin
				done_wait--;
				if (done_wait == 0 && load_done !== 1'b1)
					report_mismatch("load_done did not rise on time");
			end
			if (done_q1 && !done_q2) begin
				if (mapper_flags !== exp_flags)
					report_mismatch($sformatf("mapper_flags %h, expected %h",
						mapper_flags, exp_flags));
				if (load_error !== exp_error)
					report_mismatch($sformatf("load_error %b, expected %b",
						load_error, exp_error));
			end

			if (mem.write === 1'b1) begin
				if (exp_q.size() == 0) begin
					report_mismatch($sformatf("unexpected write to %h", mem.addr));
				end else begin
					exp_w = exp_q.pop_front();
					if ({mem.addr, mem.data} !== exp_w)
						report_mismatch($sformatf("write %h = %h, expected %h = %h",
							mem.addr, mem.data, exp_w[29:8], exp_w[7:0]));
				end
			end

			if (downloading && !downloading_q) begin
				hdr_cnt = 0;
				payload_cnt = 0;
			end
			if (downloading && load.strobe) begin
				if (hdr_cnt < 16) begin
					hdr[hdr_cnt] = load.byte_data;
					hdr_cnt++;
					if (hdr_cnt == 16) begin
						prg_len = int'(hdr[4]) * 16384;  // 16 KiB pages
						chr_len = int'(hdr[5]) * 8192;   // 8 KiB pages
						if (exp_error)
							done_wait = 1;
					end
				end else if (!exp_error && payload_cnt < prg_len + chr_len) begin
					if (payload_cnt < prg_len)
						exp_w = {22'(payload_cnt), load.byte_data};
					else
						exp_w = {22'h200000 + 22'(payload_cnt - prg_len), load.byte_data};
					exp_q.push_back(exp_w);
					payload_cnt++;
					if (payload_cnt == prg_len + chr_len)
						done_wait = (chr_len == 0) ? 3 : 2;
				end
			end

			// Post-download reset length for accepted images
			if (downloading_q && !downloading && !exp_error) begin
				counting = 1'b1;
				high_cycles = 0;
			end
			if (counting) begin
				if (nes_reset) begin
					high_cycles++;
					if (high_cycles > 255) begin
						report_mismatch("nes_reset held longer than 255 cycles");
						counting = 1'b0;
					end
				end else begin
					if (high_cycles != 255)
						report_mismatch($sformatf("nes_reset held %0d cycles, expected 255",
							high_cycles));
					counting = 1'b0;
				end
			end

			if (nes_reset) begin
				pad_valid = 1'b0;
			end else if (joypad.strobe) begin
				pad_src[0] = joy_swap ? joy_b : joy_a;
				pad_src[1] = joy_swap ? joy_a : joy_b;
				pad_idx[0] = 0;
				pad_idx[1] = 0;
				pad_valid = 1'b1;
			end else if (pad_valid) begin
				for (int p = 0; p < 2; p++) begin
					if (joypad_data[p] !== first_out_bit(pad_src[p], pad_idx[p]))
						report_mismatch($sformatf("joypad port %0d bit %0d is %b", p,
							pad_idx[p], joypad_data[p]));
					if (clocks_q[p] && !joypad.clocks[p])
						pad_idx[p]++;
				end
			end
		end

		pending_writes = exp_q.size();
		reset_q = reset;
		downloading_q = downloading;
		done_q2 = done_q1;
		done_q1 = load_done;
		clocks_q = joypad.clocks;
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 20 ns clock, reset held for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);  // Release away from the sampling edge
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* src/nes_loader_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cartridge loader and housekeeping top
// Reset control, iNES loader, write stage
// and controller ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module nes_loader_top (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             downloading,
	input  nes_loader_pkg::load_byte_t       load,
	input  logic                             invert_mirroring,
	input  logic                             user_reset,
	input  nes_input_pkg::pad_state_t        joy_a,
	input  nes_input_pkg::pad_state_t        joy_b,
	input  logic                             joy_swap,
	input  nes_input_pkg::joypad_bus_t       joypad,
	output nes_loader_pkg::rom_write_t       mem,
	output nes_loader_pkg::mapper_flags_t    mapper_flags,
	output logic                             load_done,
	output logic                             load_error,
	output logic                             nes_reset,
	output logic                             nes_run,
	output logic [nes_input_pkg::pad_ports-1:0] joypad_data
);

	nes_loader_pkg::rom_write_t loader_wr;  // Pulses with each payload strobe

	nes_reset_ctrl reset_ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.downloading (downloading),
		.load_error  (load_error),
		.user_reset  (user_reset),
		.nes_reset   (nes_reset),
		.nes_run     (nes_run)
	);

	ines_loader loader_i (
		.clk              (clk),
		.reset            (reset),
		.downloading      (downloading),
		.load             (load),
		.invert_mirroring (invert_mirroring),
		.rom_wr           (loader_wr),
		.mapper_flags     (mapper_flags),
		.done             (load_done),
		.error            (load_error)
	);

	rom_write_stage write_stage_i (
		.clk     (clk),
		.reset   (reset),
		.wr_in   (loader_wr),
		.nes_run (nes_run),
		.wr_out  (mem)
	);

	joypad_serial joypad_i (
		.clk         (clk),
		.nes_reset   (nes_reset),
		.joy_a       (joy_a),
		.joy_b       (joy_b),
		.joy_swap    (joy_swap),
		.joypad      (joypad),
		.joypad_data (joypad_data)
	);

endmodule

`default_nettype wire

/* src/joypad_serial.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller port serializer
// Shifts button state out to the console
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module joypad_serial (
	input  logic                             clk,
	input  logic                             nes_reset,
	input  nes_input_pkg::pad_state_t        joy_a,
	input  nes_input_pkg::pad_state_t        joy_b,
	input  logic                             joy_swap,
	input  nes_input_pkg::joypad_bus_t       joypad,
	output logic [nes_input_pkg::pad_ports-1:0] joypad_data
);

	nes_input_pkg::pad_state_t shift_q [nes_input_pkg::pad_ports];
	nes_input_pkg::pad_state_t port_src [nes_input_pkg::pad_ports];
	logic [nes_input_pkg::pad_ports-1:0] clocks_q;

	// The console reads A, B, select, start, up, down, left, right
	function automatic nes_input_pkg::pad_state_t to_nes_order(
		input nes_input_pkg::pad_state_t h
	);
		return {h[0], h[1], h[2], h[3], h[7], h[6], h[5], h[4]};
	endfunction

	assign port_src[0] = joy_swap ? joy_b : joy_a;
	assign port_src[1] = joy_swap ? joy_a : joy_b;

	always_ff @(posedge clk) begin
		if (nes_reset) begin
			for (int i = 0; i < nes_input_pkg::pad_ports; i++)
				shift_q[i] <= '0;
			clocks_q <= '0;
		end else begin
			for (int i = 0; i < nes_input_pkg::pad_ports; i++) begin
				if (joypad.strobe)
					shift_q[i] <= to_nes_order(port_src[i]);
				else if (!joypad.clocks[i] && clocks_q[i])  // Falling read clock
					shift_q[i] <= {1'b0, shift_q[i][nes_input_pkg::pad_bits-1:1]};
			end
			clocks_q <= joypad.clocks;
		end
	end

	always_comb begin
		for (int i = 0; i < nes_input_pkg::pad_ports; i++)
			joypad_data[i] = shift_q[i][0];
	end

endmodule

`default_nettype wire

/* src/rom_write_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loader write holding stage
// Releases each write in the console's
// memory slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_write_stage (
	input  logic                       clk,
	input  logic                       reset,
	input  nes_loader_pkg::rom_write_t wr_in,
	input  logic                       nes_run,
	output nes_loader_pkg::rom_write_t wr_out
);

	logic                                       pending;  // Write waiting for its slot
	logic [nes_loader_pkg::cart_addr_width-1:0] held_addr;
	logic [7:0]                                 held_data;

	// A new write wins over the release of an older one
	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else if (wr_in.write)
			pending <= 1'b1;
		else if (nes_run)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_in.write) begin
			held_addr <= wr_in.addr;
			held_data <= wr_in.data;
		end
	end

	assign wr_out.addr = held_addr;
	assign wr_out.data = held_data;
	assign wr_out.write = pending && nes_run;  // One cycle wide

endmodule

`default_nettype wire

/* src/ines_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iNES image loader
// Parses the header, steps PRG and CHR
// addresses and builds the mapper flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ines_loader (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          downloading,
	input  nes_loader_pkg::load_byte_t    load,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::rom_write_t    rom_wr,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          done,
	output logic                          error
);

	typedef enum logic [2:0] {
		st_header,
		st_prg,
		st_chr,
		st_done,
		st_bad
	} state_t;

	state_t state;
	logic [3:0] ctr;                                        // Header byte index
	logic [7:0] ines [nes_loader_pkg::header_len];
	logic [nes_loader_pkg::cart_addr_width-1:0] addr;
	logic [nes_loader_pkg::cart_addr_width-1:0] bytes_left;
	logic [nes_loader_pkg::cart_addr_width-1:0] prg_bytes;
	logic [nes_loader_pkg::cart_addr_width-1:0] chr_bytes;
	logic downloading_q;
	logic restart;
	logic header_ok;
	logic is_nes20;
	logic is_dirty;
	nes_loader_pkg::mapper_flags_t flags_next;

	// Smallest n with pages <= 2^n, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if ({1'b0, pages} <= (9'd1 << n))
				code = 3'(n);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			downloading_q <= 1'b0;
		else
			downloading_q <= downloading;
	end

	assign restart = downloading && !downloading_q;  // New image begins

	assign prg_bytes = ines[4] << nes_loader_pkg::prg_page_shift;
	assign chr_bytes = ines[5] << nes_loader_pkg::chr_page_shift;

	// Trainers are not supported
	assign header_ok = (ines[0] == nes_loader_pkg::ines_magic0) &&
		(ines[1] == nes_loader_pkg::ines_magic1) &&
		(ines[2] == nes_loader_pkg::ines_magic2) &&
		(ines[3] == nes_loader_pkg::ines_magic3) && !ines[6][2];

	always_ff @(posedge clk) begin
		if (state == st_header && load.strobe)
			ines[ctr] <= load.byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			state <= st_header;
			ctr <= 4'd0;
			addr <= nes_loader_pkg::prg_base_addr;
			bytes_left <= '0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			case (state)
				st_header: if (load.strobe) begin
					ctr <= ctr + 4'd1;
					if (ctr == 4'(nes_loader_pkg::header_len - 1)) begin
						if (header_ok) begin
							state <= st_prg;
							addr <= nes_loader_pkg::prg_base_addr;
							bytes_left <= prg_bytes;
						end else begin
							state <= st_bad;      // Rejected as the last header byte lands
							done <= 1'b1;
							error <= 1'b1;
						end
					end
				end
				st_prg: if (bytes_left == '0) begin
					state <= st_chr;
					addr <= nes_loader_pkg::chr_base_addr;
					bytes_left <= chr_bytes;
				end else if (load.strobe) begin
					addr <= addr + 1'b1;
					bytes_left <= bytes_left - 1'b1;
				end
				st_chr: if (bytes_left == '0) begin
					state <= st_done;
					done <= 1'b1;
				end else if (load.strobe) begin
					addr <= addr + 1'b1;
					bytes_left <= bytes_left - 1'b1;
				end
				st_done, st_bad: ;                // Wait for the next download
				default: state <= st_header;
			endcase
		end
	end

	assign rom_wr.addr = addr;
	assign rom_wr.data = load.byte_data;
	assign rom_wr.write = load.strobe && (bytes_left != '0) &&
		(state == st_prg || state == st_chr);

	// NES 2.0 headers may use bytes 8 to 15; older dumps often carry junk there
	assign is_nes20 = (ines[7][3:2] == 2'b10);

	always_comb begin
		is_dirty = 1'b0;
		for (int i = 8; i < nes_loader_pkg::header_len; i++) begin
			if (ines[i] != 8'd0)
				is_dirty = !is_nes20;
		end
	end

	always_comb begin
		flags_next = '0;
		flags_next.four_screen = ines[6][3];
		flags_next.chr_ram = (ines[5] == 8'd0);
		flags_next.mirroring = ines[6][0] ^ invert_mirroring;
		flags_next.chr_size = size_code(ines[5]);
		flags_next.prg_size = size_code(ines[4]);
		flags_next.mapper = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
	end

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (done)
			mapper_flags <= flags_next;
	end

endmodule

`default_nettype wire

/* src/nes_reset_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Console reset and run-enable control
// Holds the core in reset around downloads
// and runs it one cycle in four
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module nes_reset_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic downloading,
	input  logic load_error,
	input  logic user_reset,
	output logic nes_reset,
	output logic nes_run
);

	logic       init_reset;         // No image loaded yet
	logic [7:0] download_cnt;
	logic [1:0] ce_cnt;

	// Nothing to run until the first image arrives
	always_ff @(posedge clk) begin
		if (reset)
			init_reset <= 1'b1;
		else if (downloading)
			init_reset <= 1'b0;
	end

	// Keeps the core in reset for a while after the download ends
	always_ff @(posedge clk) begin
		if (reset)
			download_cnt <= 8'd0;
		else if (downloading)
			download_cnt <= 8'd255;
		else if (download_cnt != 8'd0)
			download_cnt <= download_cnt - 8'd1;
	end

	// Free running, so the core still sees clock enables in reset
	always_ff @(posedge clk) begin
		if (reset)
			ce_cnt <= 2'd0;
		else
			ce_cnt <= ce_cnt + 2'd1;
	end

	assign nes_run = (ce_cnt == 2'd3);
	assign nes_reset = reset || init_reset || (download_cnt != 8'd0) ||
		user_reset || load_error;

endmodule

`default_nettype wire

/* src/nes_input_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller input definitions
// Button widths and the console joypad bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package nes_input_pkg;

	localparam int pad_bits = 8;   // Buttons per controller
	localparam int pad_ports = 2;

	// Host order, bit 0 up to 7:
	// right, left, down, up, A, B, select, start
	typedef logic [pad_bits-1:0] pad_state_t;

	// Driven by the console's controller port
	typedef struct packed {
		logic                 strobe;
		logic [pad_ports-1:0] clocks;  // One read clock per port
	} joypad_bus_t;

endpackage

`default_nettype wire

/* src/nes_loader_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cartridge loader definitions
// Memory layout, iNES header constants and
// the structs passed between loader blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package nes_loader_pkg;

	localparam int cart_addr_width = 22;
	localparam int header_len = 16;          // iNES header bytes

	localparam logic [cart_addr_width-1:0] prg_base_addr = 22'h000000;
	localparam logic [cart_addr_width-1:0] chr_base_addr = 22'h200000;

	localparam int prg_page_shift = 14;      // 16 KiB PRG pages
	localparam int chr_page_shift = 13;      // 8 KiB CHR pages

	localparam logic [7:0] ines_magic0 = 8'h4E;  // N
	localparam logic [7:0] ines_magic1 = 8'h45;  // E
	localparam logic [7:0] ines_magic2 = 8'h53;  // S
	localparam logic [7:0] ines_magic3 = 8'h1A;

	// One downloaded byte with its strobe
	typedef struct packed {
		logic [7:0] byte_data;
		logic       strobe;
	} load_byte_t;

	typedef struct packed {
		logic [cart_addr_width-1:0] addr;
		logic [7:0]                 data;
		logic                       write;
	} rom_write_t;

	// Cartridge description handed to the console core
	typedef struct packed {
		logic [14:0] reserved;
		logic        four_screen;
		logic        chr_ram;
		logic        mirroring;
		logic [2:0]  chr_size;
		logic [2:0]  prg_size;
		logic [7:0]  mapper;
	} mapper_flags_t;

endpackage

`default_nettype wire
